// File: design/bk_cfg.svh
// BK peripheral configuration
`ifndef BK_CFG_SVH
`define BK_CFG_SVH

//////////////////////////////////////////////////
// Clock enable dividers
//////////////////////////////////////////////////
// Terminal count of the CPU divider on a BK0011M
`define BK_CPU_DIV_BASE 23
`define BK_CPU_DIV_BK0010_ADD 8
// Negative phase position within the CPU period
`define BK_CPU_NEG_BASE 12
`define BK_CPU_NEG_BK0010_ADD 4
`define BK_PSG_DIV 56

// Register addresses, octal as on the real machine
`define BK_SYSREG_ADDR 16'o177716
`define BK_PORT_ADDR 16'o177714

// Mouse motion thresholds
`define BK_MOUSE_POS_TH 3
`define BK_MOUSE_NEG_TH 2

`define BK_DAC_BITS 10
`define BK_DATA_W 16

`endif

// File: design/bk_bus_pkg.sv
// APB register bus types
`default_nettype none

`include "bk_cfg.svh"

package bk_bus_pkg;

	//////////////////////////////////////////////////
	// Bus data
	//////////////////////////////////////////////////
	typedef logic [`BK_DATA_W-1:0] bk_word_t;

	// One strobe per byte lane
	typedef logic [`BK_DATA_W/8-1:0] bk_strb_t;

	// Register hit by the current address
	typedef enum logic [1:0] {
		REG_NONE,
		REG_SYSREG,
		REG_PORT
	} bk_reg_e;

	// Transfer phase as seen by the slave
	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} bk_apb_phase_e;

endpackage

`default_nettype wire

// File: design/bk_audio_pkg.sv
// Sound path types
`default_nettype none

`include "bk_cfg.svh"

package bk_audio_pkg;

	//////////////////////////////////////////////////
	// Samples and levels
	//////////////////////////////////////////////////

	// Unsigned DAC sample
	typedef logic [`BK_DAC_BITS-1:0] bk_sample_t;

	// Speaker bits 6, 5 and 2 of the system register
	typedef logic [2:0] bk_spk_t;

	// One PSG channel level
	typedef logic [7:0] bk_psg_ch_t;

endpackage

`default_nettype wire

// File: design/bk_clock_enables.sv
// CPU and PSG clock enables
`timescale 1ns/1ps
`default_nettype none

`include "bk_cfg.svh"

module bk_clock_enables (
	input  wire logic clk_sys,
	input  wire logic arst_n_i,
	input  wire logic turbo_i,
	input  wire logic bk0010_i,
	output logic      ce_cpu_p_o,
	output logic      ce_cpu_n_o,
	output logic      ce_psg_o
);

	logic [4:0] cpu_div_q;
	logic [5:0] psg_div_q;
	logic       turbo_q;
	logic [4:0] cpu_last;
	logic [4:0] cpu_neg;

	// Turbo halves both the period and the negative phase position
	assign cpu_last = 5'((`BK_CPU_DIV_BASE + (bk0010_i ? `BK_CPU_DIV_BK0010_ADD : 0)) >> turbo_q);
	assign cpu_neg  = 5'((`BK_CPU_NEG_BASE + (bk0010_i ? `BK_CPU_NEG_BK0010_ADD : 0)) >> turbo_q);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cpu_div_q  <= '0;
			psg_div_q  <= '0;
			turbo_q    <= 1'b0;
			ce_cpu_p_o <= 1'b0;
			ce_cpu_n_o <= 1'b0;
			ce_psg_o   <= 1'b0;
		end else begin
			if (cpu_div_q == cpu_last) begin
				cpu_div_q <= '0;
				// New speed only at a period boundary
				turbo_q   <= turbo_i;
			end else begin
				cpu_div_q <= cpu_div_q + 5'd1;
			end
			ce_cpu_p_o <= (cpu_div_q == 5'd0);
			ce_cpu_n_o <= (cpu_div_q == cpu_neg);

			if (psg_div_q == 6'(`BK_PSG_DIV - 1))
				psg_div_q <= '0;
			else
				psg_div_q <= psg_div_q + 6'd1;
			ce_psg_o <= (psg_div_q == 6'd0);
		end
	end

	// Both CPU phases in one cycle would clock the core twice
	ce_phase_excl: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		!(ce_cpu_p_o && ce_cpu_n_o))
		else $error("ce_cpu_p_o and ce_cpu_n_o high together");

endmodule

`default_nettype wire

// File: design/bk_sysreg_apb.sv
// System register and parallel port
`timescale 1ns/1ps
`default_nettype none

`include "bk_cfg.svh"

module bk_sysreg_apb
	import bk_bus_pkg::*;
	import bk_audio_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     arst_n_i,
	input  wire bk_word_t paddr_i,
	input  wire logic     psel_i,
	input  wire logic     penable_i,
	input  wire logic     pwrite_i,
	input  wire bk_word_t pwdata_i,
	input  wire bk_strb_t pstrb_i,
	output bk_word_t      prdata_o,
	output logic          pready_o,
	output logic          pslverr_o,
	input  wire logic     key_down_i,
	input  wire logic     key_stop_i,
	input  wire logic     bk0010_i,
	input  wire logic [6:0] mouse_state_i,
	input  wire logic     mouse_sel_i,
	input  wire logic [7:0] joystick_i,
	output bk_spk_t       spk_o,
	output logic          mouse_cfg_we_o,
	output logic          mouse_en_o,
	output logic          stop_irq_o
);

	bk_reg_e       reg_sel;
	bk_apb_phase_e apb_phase;
	bk_apb_phase_e phase_q;
	logic          sys_wr;
	logic          port_wr;
	logic          stop_block_q;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	always_comb begin
		if (paddr_i == `BK_SYSREG_ADDR)
			reg_sel = REG_SYSREG;
		else if (paddr_i == `BK_PORT_ADDR)
			reg_sel = REG_PORT;
		else
			reg_sel = REG_NONE;
	end

	always_comb begin
		if (!psel_i)
			apb_phase = IDLE;
		else if (!penable_i)
			apb_phase = SETUP;
		else
			apb_phase = ACCESS;
	end

	// No wait states
	assign pready_o  = 1'b1;
	assign pslverr_o = (apb_phase == ACCESS) && (reg_sel == REG_NONE);

	assign sys_wr  = (apb_phase == ACCESS) && pwrite_i && (reg_sel == REG_SYSREG);
	assign port_wr = (apb_phase == ACCESS) && pwrite_i && (reg_sel == REG_PORT) && pstrb_i[0];

	//////////////////////////////////////////////////
	// Register writes
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phase_q        <= IDLE;
			stop_block_q   <= 1'b0;
			spk_o          <= '0;
			mouse_en_o     <= 1'b0;
			mouse_cfg_we_o <= 1'b0;
		end else begin
			phase_q <= apb_phase;
			// Bit 11 set in the high byte means the write is not for us
			if (sys_wr && pstrb_i[1] && !pwdata_i[11])
				stop_block_q <= pwdata_i[12];
			if (sys_wr && pstrb_i[0] && (!pstrb_i[1] || !pwdata_i[11]))
				spk_o <= {pwdata_i[6], pwdata_i[5], pwdata_i[2] & !bk0010_i};
			if (port_wr)
				mouse_en_o <= pwdata_i[3];
			mouse_cfg_we_o <= port_wr;
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////
	always_comb begin
		prdata_o = '0;
		case (reg_sel)
			REG_SYSREG: begin
				prdata_o[12] = stop_block_q;
				prdata_o[7]  = 1'b1;
				prdata_o[6]  = ~key_down_i;
			end
			REG_PORT: begin
				if (mouse_sel_i)
					prdata_o[6:0] = mouse_state_i;
				else
					prdata_o[7:0] = joystick_i;
			end
			default: prdata_o = '0;
		endcase
	end

	assign stop_irq_o = key_stop_i & ~stop_block_q;

	// Access cycle must follow a setup cycle
	apb_enable_after_setup: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		penable_i |-> (phase_q == SETUP))
		else $error("penable without a preceding setup cycle");

	apb_err_in_access: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		pslverr_o |-> (phase_q == SETUP) && (apb_phase == ACCESS))
		else $error("pslverr outside the access phase");

endmodule

`default_nettype wire

// File: design/bk_mouse_tracker.sv
// Mouse direction tracker
`timescale 1ns/1ps
`default_nettype none

`include "bk_cfg.svh"

module bk_mouse_tracker (
	input  wire logic       clk_sys,
	input  wire logic       arst_n_i,
	input  wire logic       mouse_ready_i,
	input  wire logic [7:0] mouse_counter_i,
	input  wire logic [8:0] mouse_dx_i,
	input  wire logic [8:0] mouse_dy_i,
	input  wire logic       mouse_left_i,
	input  wire logic       mouse_right_i,
	input  wire logic [7:0] joystick_i,
	input  wire logic       mouse_cfg_we_i,
	input  wire logic       mouse_en_i,
	output logic [6:0]      mouse_state_o,
	output logic            mouse_sel_o
);

	logic [7:0] old_counter_q;
	logic [1:0] btn_q;
	logic [3:0] dir_q;
	logic       new_sample;

	assign new_sample    = mouse_ready_i && (mouse_counter_i != old_counter_q);
	// Bit 4 is unused on the port
	assign mouse_state_o = {btn_q, 1'b0, dir_q};

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			old_counter_q <= '0;
			btn_q         <= '0;
			dir_q         <= '0;
			mouse_sel_o   <= 1'b0;
		end else begin
			btn_q <= {mouse_right_i, mouse_left_i};
			if (mouse_ready_i)
				old_counter_q <= mouse_counter_i;

			if (mouse_cfg_we_i && !mouse_en_i) begin
				dir_q <= '0;
			end else if (mouse_en_i && new_sample) begin
				// Vertical axis, bits 0 and 2
				if (!dir_q[0] && !dir_q[2]) begin
					if (!mouse_dy_i[8] && (mouse_dy_i > 9'(`BK_MOUSE_POS_TH)))
						dir_q[0] <= 1'b1;
					if (mouse_dy_i[8] && (~mouse_dy_i > 9'(`BK_MOUSE_NEG_TH)))
						dir_q[2] <= 1'b1;
				end
				// Horizontal axis, bits 1 and 3
				if (!dir_q[1] && !dir_q[3]) begin
					if (!mouse_dx_i[8] && (mouse_dx_i > 9'(`BK_MOUSE_POS_TH)))
						dir_q[1] <= 1'b1;
					if (mouse_dx_i[8] && (~mouse_dx_i > 9'(`BK_MOUSE_NEG_TH)))
						dir_q[3] <= 1'b1;
				end
			end

			// Joystick activity hands the port back unless mouse data arrives at once
			if (|joystick_i)
				mouse_sel_o <= 1'b0;
			if (mouse_ready_i)
				mouse_sel_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/bk_audio_mixer.sv
// Left and right audio mixer
`timescale 1ns/1ps
`default_nettype none

module bk_audio_mixer
	import bk_audio_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       arst_n_i,
	input  wire bk_psg_ch_t psg_a_i,
	input  wire bk_psg_ch_t psg_b_i,
	input  wire bk_psg_ch_t psg_c_i,
	input  wire logic [5:0] psg_active_i,
	input  wire bk_spk_t    spk_i,
	output bk_sample_t      sample_l_o,
	output bk_sample_t      sample_r_o
);

	bk_sample_t mix_l;
	bk_sample_t mix_r;
	bk_sample_t spk_part;

	//////////////////////////////////////////////////
	// Mix
	//////////////////////////////////////////////////
	always_comb begin
		if (|psg_active_i) begin
			// Speaker scaled by 32 under the PSG
			spk_part = {2'b00, spk_i, 5'b00000};
			mix_l    = {1'b0, psg_a_i, 1'b0} + {2'b00, psg_b_i} + spk_part;
			mix_r    = {1'b0, psg_c_i, 1'b0} + {2'b00, psg_b_i} + spk_part;
		end else begin
			// Speaker alone gets the full range
			spk_part = {spk_i, 7'b0000000};
			mix_l    = spk_part;
			mix_r    = spk_part;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sample_l_o <= '0;
			sample_r_o <= '0;
		end else begin
			sample_l_o <= mix_l;
			sample_r_o <= mix_r;
		end
	end

endmodule

`default_nettype wire

// File: design/bk_sigma_delta_dac.sv
// First-order sigma-delta DAC
`timescale 1ns/1ps
`default_nettype none

`include "bk_cfg.svh"

module bk_sigma_delta_dac
	import bk_audio_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       arst_n_i,
	input  wire bk_sample_t sample_i,
	output logic            dac_o
);

	// One extra bit holds the carry of the last addition
	logic [`BK_DAC_BITS:0] acc_q;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			acc_q <= '0;
		else
			acc_q <= {1'b0, acc_q[`BK_DAC_BITS-1:0]} + {1'b0, sample_i};
	end

	// Carry density tracks sample / 2^BK_DAC_BITS
	assign dac_o = acc_q[`BK_DAC_BITS];

endmodule

`default_nettype wire

// File: design/bk_periph_top.sv
// BK0011M peripheral top
`timescale 1ns/1ps
`default_nettype none

module bk_periph_top
	import bk_bus_pkg::*;
	import bk_audio_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       arst_n_i,
	input  wire bk_word_t   paddr_i,
	input  wire logic       psel_i,
	input  wire logic       penable_i,
	input  wire logic       pwrite_i,
	input  wire bk_word_t   pwdata_i,
	input  wire bk_strb_t   pstrb_i,
	output bk_word_t        prdata_o,
	output logic            pready_o,
	output logic            pslverr_o,
	input  wire bk_psg_ch_t psg_a_i,
	input  wire bk_psg_ch_t psg_b_i,
	input  wire bk_psg_ch_t psg_c_i,
	input  wire logic [5:0] psg_active_i,
	input  wire logic       mouse_ready_i,
	input  wire logic [7:0] mouse_counter_i,
	input  wire logic [8:0] mouse_dx_i,
	input  wire logic [8:0] mouse_dy_i,
	input  wire logic       mouse_left_i,
	input  wire logic       mouse_right_i,
	input  wire logic [7:0] joystick_i,
	input  wire logic       key_down_i,
	input  wire logic       key_stop_i,
	input  wire logic       turbo_i,
	input  wire logic       bk0010_i,
	output logic            ce_cpu_p_o,
	output logic            ce_cpu_n_o,
	output logic            ce_psg_o,
	output logic            stop_irq_o,
	output logic            audio_l_o,
	output logic            audio_r_o
);

	bk_spk_t    spk;
	logic       mouse_cfg_we;
	logic       mouse_en;
	logic [6:0] mouse_state;
	logic       mouse_sel;
	bk_sample_t sample_l;
	bk_sample_t sample_r;

	//////////////////////////////////////////////////
	// Clocking and registers
	//////////////////////////////////////////////////
	bk_clock_enables u_clk_en (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .turbo_i(turbo_i), .bk0010_i(bk0010_i),
		.ce_cpu_p_o(ce_cpu_p_o), .ce_cpu_n_o(ce_cpu_n_o), .ce_psg_o(ce_psg_o)
	);

	bk_sysreg_apb u_sysreg (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .paddr_i(paddr_i), .psel_i(psel_i),
		.penable_i(penable_i), .pwrite_i(pwrite_i), .pwdata_i(pwdata_i), .pstrb_i(pstrb_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.key_down_i(key_down_i), .key_stop_i(key_stop_i), .bk0010_i(bk0010_i),
		.mouse_state_i(mouse_state), .mouse_sel_i(mouse_sel), .joystick_i(joystick_i),
		.spk_o(spk), .mouse_cfg_we_o(mouse_cfg_we), .mouse_en_o(mouse_en),
		.stop_irq_o(stop_irq_o)
	);

	bk_mouse_tracker u_mouse (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .mouse_ready_i(mouse_ready_i),
		.mouse_counter_i(mouse_counter_i), .mouse_dx_i(mouse_dx_i), .mouse_dy_i(mouse_dy_i),
		.mouse_left_i(mouse_left_i), .mouse_right_i(mouse_right_i), .joystick_i(joystick_i),
		.mouse_cfg_we_i(mouse_cfg_we), .mouse_en_i(mouse_en),
		.mouse_state_o(mouse_state), .mouse_sel_o(mouse_sel)
	);

	//////////////////////////////////////////////////
	// Sound path
	//////////////////////////////////////////////////
	bk_audio_mixer u_mixer (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .psg_a_i(psg_a_i), .psg_b_i(psg_b_i),
		.psg_c_i(psg_c_i), .psg_active_i(psg_active_i), .spk_i(spk),
		.sample_l_o(sample_l), .sample_r_o(sample_r)
	);

	bk_sigma_delta_dac u_dac_l (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .sample_i(sample_l), .dac_o(audio_l_o)
	);

	bk_sigma_delta_dac u_dac_r (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .sample_i(sample_r), .dac_o(audio_r_o)
	);

endmodule

`default_nettype wire

// File: sim/bk_periph_tb.sv
// BK peripheral testbench
`timescale 1ns/1ps
`default_nettype none

`include "bk_cfg.svh"

module bk_periph_tb
	import bk_bus_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int CPU_GAP[4] = '{24, 12, 32, 16};
	// Negative phase position after the positive pulse, turbo halves it
	localparam int CPU_NEG_OFS[4] = '{12, 6, 16, 8};
	// Speaker bits 6 and 2 set give speaker value 3'b101
	localparam bk_word_t SPK_WORD = 16'h0044;
	localparam int SPK_VAL = 5;
	localparam int CLK_TEST_CYCLES = 5 * 3 * 64;
	localparam int DAC_TEST_CYCLES = 4 * (1024 + 16);
	localparam int BUS_TEST_CYCLES = 400;
	localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
		(CLK_TEST_CYCLES + DAC_TEST_CYCLES + BUS_TEST_CYCLES);

	logic clk_sys;
	logic arst_n_i;
	bk_word_t paddr_i;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	bk_word_t pwdata_i;
	bk_strb_t pstrb_i;
	bk_word_t prdata_o;
	logic pready_o;
	logic pslverr_o;
	logic [7:0] psg_a_i;
	logic [7:0] psg_b_i;
	logic [7:0] psg_c_i;
	logic [5:0] psg_active_i;
	logic mouse_ready_i;
	logic [7:0] mouse_counter_i;
	logic [8:0] mouse_dx_i;
	logic [8:0] mouse_dy_i;
	logic mouse_left_i;
	logic mouse_right_i;
	logic [7:0] joystick_i;
	logic key_down_i;
	logic key_stop_i;
	logic turbo_i;
	logic bk0010_i;
	logic ce_cpu_p_o;
	logic ce_cpu_n_o;
	logic ce_psg_o;
	logic stop_irq_o;
	logic audio_l_o;
	logic audio_r_o;
	int value_errors = 0;
	int other_errors = 0;

	bk_periph_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Bus protocol checks
	//////////////////////////////////////////////////
	pready_high: assert property (@(posedge clk_sys) disable iff (!arst_n_i) pready_o)
	else begin
		other_errors++;
		$display("pready_o went low although the slave has no wait states");
	end

	err_in_access: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		pslverr_o |-> psel_i && penable_i)
	else begin
		other_errors++;
		$display("pslverr_o was raised outside an access cycle");
	end

	stop_needs_key: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		stop_irq_o |-> key_stop_i)
	else begin
		other_errors++;
		$display("stop_irq_o was high without the STOP key");
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic bk_word_t reg_addr(input bk_reg_e sel);
		case (sel)
			REG_SYSREG: return `BK_SYSREG_ADDR;
			REG_PORT: return `BK_PORT_ADDR;
			default: return 16'h1234;
		endcase
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_word(input string name, input bk_word_t expected, input bk_word_t actual);
		assert (actual == expected)
		else begin
			value_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual,
		input int tol);
		int diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		assert (diff <= tol)
		else begin
			value_errors++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// Access cycle lasts until pready or a bounded wait ends
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!pready_o && n < 16) begin
			@(negedge clk_sys);
			n++;
		end
		if (!pready_o) begin
			other_errors++;
			$display("APB transfer saw no pready within 16 cycles");
		end
	endtask

	task automatic write_reg(input bk_word_t addr, input bk_word_t data, input bk_strb_t strb);
		step();
		paddr_i = addr;
		pwdata_i = data;
		pstrb_i = strb;
		pwrite_i = 1'b1;
		psel_i = 1'b1;
		step();
		penable_i = 1'b1;
		wait_ready();
		step();
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic fetch_reg(input bk_word_t addr, output bk_word_t data, output logic err);
		step();
		paddr_i = addr;
		pwrite_i = 1'b0;
		pstrb_i = '0;
		psel_i = 1'b1;
		step();
		penable_i = 1'b1;
		wait_ready();
		data = prdata_o;
		err = pslverr_o;
		step();
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	// Cycles between two consecutive enable pulses
	task automatic pulse_gap(input logic psg, output int gap);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(psg ? ce_psg_o : ce_cpu_p_o) && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!(psg ? ce_psg_o : ce_cpu_p_o) && gap < 200);
		if (gap >= 200 || n >= 200) begin
			other_errors++;
			$display("Clock enable pulse missing for 200 cycles");
		end
	endtask

	// Cycles from a positive CPU enable to the next negative one
	task automatic neg_phase_offset(output int ofs);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!ce_cpu_p_o && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		ofs = 0;
		do begin
			@(negedge clk_sys);
			ofs++;
		end while (!ce_cpu_n_o && ofs < 200);
		if (ofs >= 200 || n >= 200) begin
			other_errors++;
			$display("Negative CPU enable missing for 200 cycles");
		end
	endtask

	task automatic count_ones(input int cycles, output int ones_l, output int ones_r);
		ones_l = 0;
		ones_r = 0;
		repeat (cycles) begin
			@(negedge clk_sys);
			if (audio_l_o)
				ones_l++;
			if (audio_r_o)
				ones_r++;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin
		bk_word_t rd;
		logic err;
		int gap;
		int ofs;
		int ones_l;
		int ones_r;
		int exp_l;
		int exp_r;
		int dx_val;
		logic [3:0] dir_exp;
		void'($urandom(32'h871e_52f3));
		arst_n_i = 1'b0;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		pstrb_i = '0;
		psg_a_i = '0;
		psg_b_i = '0;
		psg_c_i = '0;
		psg_active_i = '0;
		mouse_ready_i = 1'b0;
		mouse_counter_i = '0;
		mouse_dx_i = '0;
		mouse_dy_i = '0;
		mouse_left_i = 1'b0;
		mouse_right_i = 1'b0;
		joystick_i = 8'h5a;
		key_down_i = 1'b0;
		key_stop_i = 1'b0;
		turbo_i = 1'b0;
		bk0010_i = 1'b0;
		repeat (3) @(posedge clk_sys);
		#2;
		arst_n_i = 1'b1;

		// Quiet outputs and port defaults after reset
		count_ones(64, ones_l, ones_r);
		check_count("reset_audio_l", 0, ones_l, 0);
		check_count("reset_audio_r", 0, ones_r, 0);
		fetch_reg(reg_addr(REG_PORT), rd, err);
		check_word("reset_port_joystick", 16'h005a, rd);
		fetch_reg(reg_addr(REG_NONE), rd, err);
		check_word("unmapped_pslverr", 16'h0001, {15'd0, err});

		// Divider spacing for each turbo and model combination
		for (int i = 0; i < 4; i++) begin
			step();
			turbo_i = i[0];
			bk0010_i = i[1];
			pulse_gap(1'b0, gap);
			pulse_gap(1'b0, gap);
			check_count("ce_cpu_gap", CPU_GAP[i], gap, 0);
			neg_phase_offset(ofs);
			check_count("ce_cpu_n_offset", CPU_NEG_OFS[i], ofs, 0);
		end
		step();
		turbo_i = 1'b0;
		bk0010_i = 1'b0;
		pulse_gap(1'b1, gap);
		check_count("ce_psg_gap", `BK_PSG_DIV, gap, 0);

		// Speaker alone at full scale
		write_reg(reg_addr(REG_SYSREG), SPK_WORD, 2'b01);
		repeat (4) @(posedge clk_sys);
		count_ones(1024, ones_l, ones_r);
		check_count("speaker_audio_l", SPK_VAL * 128, ones_l, 1);
		check_count("speaker_audio_r", SPK_VAL * 128, ones_r, 1);

		// STOP key blocking
		step();
		key_stop_i = 1'b1;
		@(negedge clk_sys);
		check_word("stop_irq_open", 16'h0001, {15'd0, stop_irq_o});
		write_reg(reg_addr(REG_SYSREG), 16'h1000, 2'b10);
		repeat (8) begin
			@(negedge clk_sys);
			check_word("stop_irq_blocked", 16'h0000, {15'd0, stop_irq_o});
		end
		fetch_reg(reg_addr(REG_SYSREG), rd, err);
		// Bit 7 reads as one, bit 6 is the inverted key_down
		check_word("sysreg_readback", 16'h10c0, rd);
		step();
		key_stop_i = 1'b0;

		// PSG mix with random levels
		for (int k = 0; k < 2; k++) begin
			step();
			psg_a_i = 8'($urandom);
			psg_b_i = 8'($urandom);
			psg_c_i = 8'($urandom);
			psg_active_i = 6'h01;
			exp_l = 2 * int'(psg_a_i) + int'(psg_b_i) + 32 * SPK_VAL;
			exp_r = 2 * int'(psg_c_i) + int'(psg_b_i) + 32 * SPK_VAL;
			repeat (4) @(posedge clk_sys);
			count_ones(1024, ones_l, ones_r);
			check_count("mixer_audio_l", exp_l, ones_l, 1);
			check_count("mixer_audio_r", exp_r, ones_r, 1);
		end

		// Mouse takes the port, then the joystick takes it back
		step();
		joystick_i = 8'h00;
		mouse_left_i = 1'b1;
		write_reg(reg_addr(REG_PORT), 16'h0008, 2'b01);
		dx_val = int'($urandom_range(16)) - 8;
		step();
		mouse_dx_i = 9'(dx_val);
		mouse_dy_i = 9'd5;
		mouse_counter_i = 8'd1;
		mouse_ready_i = 1'b1;
		step();
		mouse_ready_i = 1'b0;
		// dy of 5 is over the positive threshold
		dir_exp = {(-dx_val - 1) > `BK_MOUSE_NEG_TH, 1'b0, dx_val > `BK_MOUSE_POS_TH, 1'b1};
		fetch_reg(reg_addr(REG_PORT), rd, err);
		check_word("mouse_port_read", {9'd0, 1'b0, 1'b1, 1'b0, dir_exp}, rd);
		write_reg(reg_addr(REG_PORT), 16'h0000, 2'b01);
		fetch_reg(reg_addr(REG_PORT), rd, err);
		check_word("mouse_dir_cleared", 16'h0020, rd);
		step();
		joystick_i = 8'h21;
		fetch_reg(reg_addr(REG_PORT), rd, err);
		check_word("joystick_takeover", 16'h0021, rd);

		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/bk_bus_pkg.sv
design/bk_audio_pkg.sv
design/bk_clock_enables.sv
design/bk_sysreg_apb.sv
design/bk_mouse_tracker.sv
design/bk_audio_mixer.sv
design/bk_sigma_delta_dac.sv
design/bk_periph_top.sv
sim/bk_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BK peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module bk_periph_tb -o bk_periph_sim
./obj_dir/bk_periph_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation passed"
